//--- list.f
+incdir+tb
hw/iwmRegPkg.sv
hw/iwmTimingPkg.sv
hw/iwmBusRegs.sv
hw/iwmReadDecoder.sv
hw/iwmWriteSerializer.sv
hw/iwm.sv
tb/iwmTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= iwmTb
RTL_TOP   ?= iwm
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS = hw/iwmRegPkg.sv hw/iwmTimingPkg.sv hw/iwmBusRegs.sv \
           hw/iwmReadDecoder.sv hw/iwmWriteSerializer.sv hw/iwm.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/iwmTbModel.svh
`ifndef IWM_TB_MODEL_SVH
`define IWM_TB_MODEL_SVH

// 16-bit Galois LFSR, one step per bit taken
function automatic logic [31:0] randBits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

task automatic checkVal(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	checkCount++;
	if (expected !== actual) begin
		errCount++;
		$display("FAIL %s expected %0h actual %0h", name, expected, actual);
	end
endtask

// One falling edge at the start of each 1 cell, line held low for pulse cycles
task automatic sendFluxByte(input logic [7:0] val, input int cellLen, input int pulse);
	for (int b = 7; b >= 0; b--) begin
		for (int c = 0; c < cellLen; c++) begin
			@(negedge fclk);
			rdData = !(val[b] && c < pulse);
		end
	end
endtask

// Rebuild the bit stream from wrData transition spacing
task automatic decodeWrite(input int cellLen);
	bit         bits[$];
	int         gap;
	logic [7:0] got;
	if (toggleTimes.size() == 0) begin
		errCount++;
		$display("no transitions were seen on wrData during the write test");
		return;
	end
	bits.push_back(1'b1);
	for (int i = 1; i < toggleTimes.size(); i++) begin
		gap = toggleTimes[i] - toggleTimes[i-1];
		checkVal("write spacing", 0, gap % cellLen);
		// Gap of k cells means k-1 zeros before the next 1
		for (int k = 1; k < gap / cellLen; k++) begin
			bits.push_back(1'b0);
		end
		bits.push_back(1'b1);
	end
	while (bits.size() < 8 * wrBytes.size()) begin
		bits.push_back(1'b0);
	end
	checkVal("write length", 8 * wrBytes.size(), bits.size());
	for (int j = 0; j < wrBytes.size(); j++) begin
		for (int b = 0; b < 8; b++) begin
			got[7-b] = bits[8*j+b];
		end
		checkVal("write byte", wrBytes[j], got);
	end
endtask

`endif

//--- tb/iwmTb.sv
`timescale 1ns/1ps
`default_nettype none

module iwmTb;
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	localparam int N_STATE = 48;
	localparam int N_MODE = 12;
	localparam int N_RD = 4;
	localparam int N_WR = 5;
	// ====================
	// Run length budget
	// ====================
	localparam int T1 = 2 * N_STATE + 40;
	localparam int T2 = N_MODE * 16;
	localparam int T3 = 4 * (200 + N_RD * 400);
	localparam int T4 = (N_WR + 3) * 8 * 16 + 200;
	localparam int T5 = 2 * 8 * 16 + 100;
	localparam int LIMIT = (T1 + T2 + T3 + T4 + T5) * 6 / 5;

	logic       fclk;
	logic       nRES;
	logic [3:0] addr;
	logic       nDeviceSelect;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic       wrData;
	logic [3:0] phase;
	logic       nWrReq;
	logic       nEnbl1;
	logic       nEnbl2;
	logic       sense;
	logic       rdData;
	logic       q7Out;

	logic [15:0] lfsr;
	int          errCount;
	int          checkCount;
	int          testErr;
	int          cycleCount;
	iwmCtrl_t    modelCtrl;
	logic [7:0]  modelMode;
	logic        monOn;
	logic        wrPrev;
	int          toggleTimes[$];
	logic [7:0]  wrBytes[$];

	`include "iwmTbModel.svh"

	iwm i_dut (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn), .dataOut(dataOut), .wrData(wrData), .phase(phase),
		.nWrReq(nWrReq), .nEnbl1(nEnbl1), .nEnbl2(nEnbl2), .sense(sense),
		.rdData(rdData), .q7Out(q7Out)
	);

	always #5 fclk = ~fclk;

	// Cycle counter and hang guard
	always @(posedge fclk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// wrData transition times, sampled away from the active edge
	always @(negedge fclk) begin
		if (monOn && wrData !== wrPrev) begin
			toggleTimes.push_back(cycleCount);
		end
		wrPrev = wrData;
	end

	// Model of one bus access, uses the state before the edge
	task automatic modelAccess(input logic [3:0] a, input logic [7:0] d);
		if (modelCtrl.q7 && modelCtrl.q6 && a[0] && !modelCtrl.motorOn) begin
			modelMode = d;
		end
		case (a[3:1])
			3'd0, 3'd1, 3'd2, 3'd3: modelCtrl.phase[a[3:1]] = a[0];
			3'd4: modelCtrl.motorOn = a[0];
			3'd5: modelCtrl.driveSelect = a[0];
			3'd6: modelCtrl.q6 = a[0];
			default: modelCtrl.q7 = a[0];
		endcase
	endtask

	// One-cycle bus access, dataOut sampled after the edge
	task automatic busAccess(input logic [3:0] a, input logic [7:0] d, output logic [7:0] rd);
		@(negedge fclk);
		addr = a;
		dataIn = d;
		nDeviceSelect = 1'b0;
		@(negedge fclk);
		rd = dataOut;
		nDeviceSelect = 1'b1;
		modelAccess(a, d);
	endtask

	// Mode write with the motor off, leaves Q6 and Q7 clear
	task automatic writeMode(input logic [7:0] val);
		logic [7:0] rd;
		busAccess(4'b1101, 8'h00, rd);
		busAccess(4'b1111, 8'h00, rd);
		busAccess(4'b1111, val, rd);
		busAccess(4'b1110, 8'h00, rd);
		busAccess(4'b1100, 8'h00, rd);
	endtask

	// Data byte into the write buffer, Q7 already set
	task automatic writeByte(input logic [7:0] val);
		logic [7:0] rd;
		busAccess(4'b1101, 8'h00, rd);
		busAccess(4'b1101, val, rd);
		busAccess(4'b1100, 8'h00, rd);
	endtask

	task automatic endTest(input string name);
		if (errCount == testErr) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errCount - testErr);
		end
		testErr = errCount;
	endtask

	initial begin
		logic [7:0] rd;
		logic [7:0] val;
		logic [3:0] a;
		int         one;
		fclk = 1'b0;
		nRES = 1'b0;
		addr = 4'h0;
		nDeviceSelect = 1'b1;
		dataIn = 8'h00;
		sense = 1'b0;
		rdData = 1'b1;
		lfsr = 16'd33661;
		errCount = 0;
		checkCount = 0;
		testErr = 0;
		cycleCount = 0;
		modelCtrl = '0;
		modelMode = MODE_RESET;
		monOn = 1'b0;
		wrPrev = 1'b0;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		nRES = 1'b1;

		// ====================
		// State register
		// ====================
		for (int i = 0; i < N_STATE; i++) begin
			a = 4'(randBits(4));
			busAccess(a, 8'(randBits(8)), rd);
			checkVal("state phase", modelCtrl.phase, phase);
			checkVal("state q7", modelCtrl.q7, q7Out);
			checkVal("state enbl1", !(modelCtrl.motorOn && !modelCtrl.driveSelect), nEnbl1);
			checkVal("state enbl2", !(modelCtrl.motorOn && modelCtrl.driveSelect), nEnbl2);
		end
		for (int b = 0; b < 8; b++) begin
			busAccess(4'(b * 2), 8'h00, rd);
		end
		endTest("state");

		// ====================
		// Mode register
		// ====================
		for (int i = 0; i < N_MODE; i++) begin
			writeMode(8'(randBits(8)));
			sense = 1'(randBits(1));
			// Random motor state so the enable bit takes both values
			a = {3'b100, 1'(randBits(1))};
			busAccess(a, 8'h00, rd);
			busAccess(4'b1101, 8'h00, rd);
			checkVal("status", {sense, 1'b0, modelCtrl.motorOn, modelMode[4:0]}, rd);
			busAccess(4'b1000, 8'h00, rd);
		end
		endTest("mode");

		// Read path in all four timing modes
		for (int m = 0; m < 4; m++) begin
			writeMode({3'b000, m[0], m[1], 3'b111});
			one = ONE_THRESH[m];
			repeat (4 * one) @(negedge fclk);
			for (int i = 0; i < N_RD; i++) begin
				val = {1'b1, 7'(randBits(7))};
				sendFluxByte(val, 2 * one, one);
				rd = 8'h00;
				while (!rd[7]) begin
					busAccess(4'b1100, 8'h00, rd);
				end
				checkVal("read byte", val, rd);
				repeat (CLEAR_DELAY + 1) @(negedge fclk);
				busAccess(4'b1100, 8'h00, rd);
				checkVal("read msb clear", 0, rd[7]);
			end
		end
		endTest("read");

		// ====================
		// Write path
		// ====================
		writeMode(8'h1F);
		busAccess(4'b1001, 8'h00, rd);
		monOn = 1'b1;
		busAccess(4'b1111, 8'h00, rd);
		val = {1'b1, 7'(randBits(7))};
		wrBytes.push_back(val);
		writeByte(val);
		checkVal("write request", 0, nWrReq);
		for (int i = 1; i < N_WR; i++) begin
			rd = 8'h00;
			while (!rd[7]) begin
				busAccess(4'b1100, 8'h00, rd);
			end
			val = {1'b1, 7'(randBits(7))};
			wrBytes.push_back(val);
			writeByte(val);
		end
		// Wait for the last byte to load and shift out
		rd = 8'h00;
		while (!rd[7]) begin
			busAccess(4'b1100, 8'h00, rd);
		end
		repeat (8 * 16 + 8) @(negedge fclk);
		monOn = 1'b0;
		decodeWrite(WRITE_CELL[3] + 1);
		endTest("write");

		// Underrun, then recovery through Q7 low
		// The boundary after the last byte has already passed
		busAccess(4'b1100, 8'h00, rd);
		checkVal("underrun flag", 0, rd[6]);
		checkVal("underrun request", 1, nWrReq);
		busAccess(4'b1110, 8'h00, rd);
		repeat (2) @(negedge fclk);
		busAccess(4'b1111, 8'h00, rd);
		busAccess(4'b1100, 8'h00, rd);
		checkVal("recover flag", 1, rd[6]);
		checkVal("recover request", 0, nWrReq);
		busAccess(4'b1110, 8'h00, rd);
		busAccess(4'b1000, 8'h00, rd);
		endTest("underrun");

		$display("tests: 5, checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/iwm.sv
`timescale 1ns/1ps
`default_nettype none

module iwm (
	input  wire        fclk,
	input  wire        nRES,
	// Host bus
	input  wire  [3:0] addr,
	input  wire        nDeviceSelect,
	input  wire  [7:0] dataIn,
	output logic [7:0] dataOut,
	// Drive side
	output logic       wrData,
	output logic [3:0] phase,
	output logic       nWrReq,
	output logic       nEnbl1,
	output logic       nEnbl2,
	input  wire        sense,
	input  wire        rdData,
	// Q7 copy for the drive
	output logic       q7Out
);
	import iwmRegPkg::*;

	iwmCtrl_t   ctrl;
	iwmMode_t   mode;
	writeStat_t wstat;
	logic       dataWrite;
	logic       dataRead;
	logic [7:0] readByte;

	// Bus front stage, owns state and mode
	iwmBusRegs uBusRegs (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn), .sense(sense), .readByte(readByte), .wstat(wstat),
		.ctrl(ctrl), .mode(mode), .dataWrite(dataWrite), .dataRead(dataRead),
		.dataOut(dataOut), .nEnbl1(nEnbl1), .nEnbl2(nEnbl2), .nWrReq(nWrReq),
		.phase(phase), .q7Out(q7Out)
	);

	// Flux in, bytes out
	iwmReadDecoder uReadDecoder (
		.fclk(fclk), .nRES(nRES), .rdData(rdData), .ctrl(ctrl), .mode(mode),
		.dataRead(dataRead), .readByte(readByte)
	);

	// Bytes in, transitions out
	iwmWriteSerializer uWriteSerializer (
		.fclk(fclk), .nRES(nRES), .ctrl(ctrl), .mode(mode), .dataWrite(dataWrite),
		.dataIn(dataIn), .wrData(wrData), .wstat(wstat)
	);

endmodule

`default_nettype wire

//--- hw/iwmWriteSerializer.sv
`timescale 1ns/1ps
`default_nettype none

module iwmWriteSerializer (
	input  wire                    fclk,
	input  wire                    nRES,
	input  wire iwmRegPkg::iwmCtrl_t ctrl,
	input  wire iwmRegPkg::iwmMode_t mode,
	input  wire                    dataWrite,
	input  wire  [7:0]             dataIn,
	output logic                   wrData,
	output iwmRegPkg::writeStat_t  wstat
);
	import iwmTimingPkg::*;

	logic [CELL_W-1:0] cellLast;
	logic [CELL_W-1:0] wrTimer;
	logic [2:0]        wrCount;
	logic [7:0]        wrShift;
	logic [7:0]        wrBuf;
	logic              q7Prev;

	assign cellLast = WRITE_CELL[{mode.fast, mode.clk8MHz}];

	// Host byte waits here until the next byte boundary
	always_ff @(posedge fclk) begin
		if (dataWrite) begin
			wrBuf <= dataIn;
		end
	end

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			wrTimer           <= '0;
			wrCount           <= 3'd7;
			wrShift           <= '0;
			q7Prev            <= 1'b0;
			wrData            <= 1'b0;
			wstat.bufferEmpty <= 1'b1;
			wstat.underrunN   <= 1'b1;
		end else begin
			q7Prev <= ctrl.q7;

			if (ctrl.q7) begin
				if (!q7Prev) begin
					// Entry into write mode, all-ones lead-in byte
					// Timer starts at 2 so the first toggle is a full cell away
					wrTimer <= 6'd2;
					wrCount <= 3'd7;
					wrShift <= 8'hFF;
				end else begin
					if (wrTimer >= cellLast) begin
						wrTimer <= '0;
						if (wrCount == 3'd7) begin
							// Byte boundary
							wrCount <= 3'd0;
							if (!wstat.bufferEmpty) begin
								wrShift           <= wrBuf;
								wstat.bufferEmpty <= 1'b1;
							end else begin
								// Nothing queued, last bit leaves the shifter
								wstat.underrunN <= 1'b0;
								wrShift         <= {wrShift[6:0], 1'b0};
							end
						end else begin
							wrCount <= wrCount + 1'b1;
							wrShift <= {wrShift[6:0], 1'b0};
						end
					end else begin
						wrTimer <= wrTimer + 1'b1;
					end

					// One transition per 1 bit, early in the cell
					if (wrTimer == 6'd1 && wrShift[7]) begin
						wrData <= ~wrData;
					end
				end
			end else begin
				wstat.underrunN <= 1'b1;
			end

			// Host write refills the buffer, beats a same-cycle load
			if (dataWrite) begin
				wstat.bufferEmpty <= 1'b0;
			end
		end
	end

	assert property (@(posedge fclk) disable iff (!nRES)
		(wrData != $past(wrData)) |-> ($past(wrTimer) == 6'd1));

endmodule

`default_nettype wire

//--- hw/iwmReadDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module iwmReadDecoder (
	input  wire                    fclk,
	input  wire                    nRES,
	input  wire                    rdData,
	input  wire iwmRegPkg::iwmCtrl_t ctrl,
	input  wire iwmRegPkg::iwmMode_t mode,
	input  wire                    dataRead,
	output logic [7:0]             readByte
);
	import iwmTimingPkg::*;

	logic [1:0]        rdSync;
	logic              fallEdge;
	logic [1:0]        timeSel;
	logic [CELL_W-1:0] oneThresh;
	logic [CELL_W-1:0] zeroThresh;
	logic [CELL_W-1:0] bitTimer;
	logic [7:0]        shifter;
	logic [7:0]        shiftVal;
	logic              shiftEn;
	logic              bitIn;
	logic [7:0]        dataReg;
	logic [3:0]        clrCnt;

	// ====================
	// Cell windows
	// ====================

	assign timeSel    = {mode.fast, mode.clk8MHz};
	assign oneThresh  = ONE_THRESH[timeSel];
	assign zeroThresh = ZERO_THRESH[timeSel];

	// Flux transition shows as a falling edge after the synchronizer
	assign fallEdge = rdSync[1] & ~rdSync[0];

	// Shift decision for this cycle
	// Early edges are noise and only restart the cell
	always_comb begin
		shiftEn = 1'b0;
		bitIn   = 1'b0;
		if (!ctrl.q7) begin
			if (fallEdge) begin
				shiftEn = (bitTimer >= oneThresh);
				bitIn   = 1'b1;
			end else if (bitTimer >= zeroThresh) begin
				shiftEn = 1'b1;
			end
		end
	end

	assign shiftVal = {shifter[6:0], bitIn};

	// ====================
	// Decoder state
	// ====================

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			rdSync   <= '0;
			bitTimer <= '0;
			shifter  <= '0;
			dataReg  <= '0;
			clrCnt   <= '0;
		end else begin
			rdSync <= {rdSync[0], rdData};

			// Write mode parks the read path
			if (ctrl.q7) begin
				bitTimer <= '0;
				shifter  <= '0;
			end else if (fallEdge) begin
				bitTimer <= '0;
			end else if (bitTimer >= zeroThresh) begin
				// Missing edge, next cell already half elapsed
				bitTimer <= oneThresh;
			end else begin
				bitTimer <= bitTimer + 1'b1;
			end

			// MSB clear timer, armed by the first read of a valid byte
			if (clrCnt != 4'd0) begin
				if (clrCnt == CLEAR_DELAY) begin
					dataReg[7] <= 1'b0;
					clrCnt     <= 4'd0;
				end else begin
					clrCnt <= clrCnt + 1'b1;
				end
			end else if (dataRead && dataReg[7]) begin
				clrCnt <= 4'd1;
			end

			// Byte complete once a 1 reaches the MSB
			// A fresh byte wins over a pending clear
			if (shiftEn) begin
				if (shiftVal[7]) begin
					dataReg <= shiftVal;
					shifter <= '0;
					clrCnt  <= 4'd0;
				end else begin
					shifter <= shiftVal;
				end
			end
		end
	end

	assign readByte = dataReg;

	// Mode only changes in write mode, which parks the timer
	assert property (@(posedge fclk) disable iff (!nRES) bitTimer <= zeroThresh);

endmodule

`default_nettype wire

//--- hw/iwmBusRegs.sv
`timescale 1ns/1ps
`default_nettype none

module iwmBusRegs (
	input  wire                    fclk,
	input  wire                    nRES,
	input  wire  [3:0]             addr,
	input  wire                    nDeviceSelect,
	input  wire  [7:0]             dataIn,
	input  wire                    sense,
	input  wire  [7:0]             readByte,
	input  wire  iwmRegPkg::writeStat_t wstat,
	output iwmRegPkg::iwmCtrl_t    ctrl,
	output iwmRegPkg::iwmMode_t    mode,
	output logic                   dataWrite,
	output logic                   dataRead,
	output logic [7:0]             dataOut,
	output logic                   nEnbl1,
	output logic                   nEnbl2,
	output logic                   nWrReq,
	output logic [3:0]             phase,
	output logic                   q7Out
);
	import iwmRegPkg::*;

	stateBit_e bitSel;
	readSel_e  rdSel;
	logic      devSel;
	logic      regWrite;
	logic      enableActive;

	// ====================
	// Bus decode
	// ====================

	assign devSel = ~nDeviceSelect;
	assign bitSel = stateBit_e'(addr[3:1]);

	// Write cycle: Q7, Q6 and A0 all high
	// Motor-on picks data buffer or mode register
	assign regWrite  = devSel & ctrl.q7 & ctrl.q6 & addr[0];
	assign dataWrite = regWrite & ctrl.motorOn;

	// Data register read, A0 low with Q7 and Q6 clear
	assign dataRead = devSel & ~addr[0] & ~ctrl.q7 & ~ctrl.q6;

	// ====================
	// State and mode
	// ====================

	// Level access, so every edge of one bus cycle re-latches the same bit
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			ctrl <= '0;
			mode <= iwmMode_t'(MODE_RESET);
		end else if (devSel) begin
			case (bitSel)
				PH0:     ctrl.phase[0]    <= addr[0];
				PH1:     ctrl.phase[1]    <= addr[0];
				PH2:     ctrl.phase[2]    <= addr[0];
				PH3:     ctrl.phase[3]    <= addr[0];
				MOTOR:   ctrl.motorOn     <= addr[0];
				DRIVE:   ctrl.driveSelect <= addr[0];
				Q6:      ctrl.q6          <= addr[0];
				default: ctrl.q7          <= addr[0];
			endcase
			// Mode write only with the motor off
			if (regWrite && !ctrl.motorOn) begin
				mode <= iwmMode_t'(dataIn);
			end
		end
	end

	// Drive enables follow motor-on, steered by drive select
	assign nEnbl1       = ~(ctrl.motorOn & ~ctrl.driveSelect);
	assign nEnbl2       = ~(ctrl.motorOn & ctrl.driveSelect);
	assign enableActive = ~nEnbl1 | ~nEnbl2;

	// Write request drops out on underrun
	assign nWrReq = ~(ctrl.q7 & wstat.underrunN & enableActive);

	assign phase = ctrl.phase;
	assign q7Out = ctrl.q7;

	// ====================
	// Read multiplexer
	// ====================

	assign rdSel = readSel_e'({ctrl.q7, ctrl.q6});

	always_comb begin
		case (rdSel)
			RD_DATA:      dataOut = readByte;
			// Sense, zero, enable active, mode bits 4 to 0
			RD_STATUS:    dataOut = {sense, 1'b0, enableActive, mode.clk8MHz, mode.fast,
			                         mode.timerOff, mode.async, mode.latch};
			RD_HANDSHAKE: dataOut = {wstat.bufferEmpty, wstat.underrunN, 6'b000000};
			default:      dataOut = 8'hFF;
		endcase
	end

	// Only one drive may ever be selected
	assert property (@(posedge fclk) disable iff (!nRES) !(!nEnbl1 && !nEnbl2));

endmodule

`default_nettype wire

//--- hw/iwmTimingPkg.sv
`default_nettype none

package iwmTimingPkg;

	// Width of the read and write bit timers
	localparam int CELL_W = 6;

	// ====================
	// Bit-cell tables
	// ====================

	// All tables are indexed by {fast, clk8MHz}
	// Entry order: slow 7M, slow 8M, fast 7M, fast 8M
	// Slow mode counts are doubled since the timers run on fclk

	// Earliest falling edge that still counts as a 1
	localparam logic [CELL_W-1:0] ONE_THRESH [4] = '{
		6'd14, 6'd16, 6'd7, 6'd8
	};

	// No edge by this count means a 0 cell
	localparam logic [CELL_W-1:0] ZERO_THRESH [4] = '{
		6'd42, 6'd48, 6'd21, 6'd24
	};

	// Write cell length minus one
	// Timer runs 0 to this value inclusive
	localparam logic [CELL_W-1:0] WRITE_CELL [4] = '{
		6'd27, 6'd31, 6'd13, 6'd15
	};

	// fclk cycles from a data read to the MSB clear
	localparam logic [3:0] CLEAR_DELAY = 4'd14;

endpackage

`default_nettype wire

//--- hw/iwmRegPkg.sv
`default_nettype none

package iwmRegPkg;

	// ====================
	// State register
	// ====================

	// One bit per bus access, value taken from addr bit 0
	typedef struct packed {
		logic [3:0] phase;
		logic       motorOn;
		logic       driveSelect;
		logic       q6;
		logic       q7;
	} iwmCtrl_t;

	// State bit addressed by addr bits 3 to 1
	typedef enum logic [2:0] {
		PH0, PH1, PH2, PH3, MOTOR, DRIVE, Q6, Q7
	} stateBit_e;

	// ====================
	// Mode register
	// ====================

	// Upper three bits are stored but never read back
	typedef struct packed {
		logic [1:0] reserved;
		logic       test;
		logic       clk8MHz;
		logic       fast;
		logic       timerOff;
		logic       async;
		logic       latch;
	} iwmMode_t;

	// Latch, async and timer-off set out of reset
	localparam logic [7:0] MODE_RESET = 8'h07;

	// Read register chosen by {Q7, Q6}
	typedef enum logic [1:0] {
		RD_DATA, RD_STATUS, RD_HANDSHAKE, RD_ONES
	} readSel_e;

	// Write handshake flags from the serializer
	typedef struct packed {
		logic bufferEmpty;
		logic underrunN;
	} writeStat_t;

endpackage

`default_nettype wire
